// File: Makefile
TOP := memory_system_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --top-module $(TOP) -f memory_system.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           read,
	input  logic                           write,
	input  logic [cache_pkg::addr_width-1:0] addr,
	input  logic [cache_pkg::word_width-1:0] wdata,
	output logic [cache_pkg::word_width-1:0] rdata,
	output logic                           stall,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic [cache_pkg::addr_width-1:0] mem_addr,
	output logic [cache_pkg::word_width-1:0] mem_wdata,
	input  logic                           mem_grant,
	input  logic                           mem_valid,
	input  logic [cache_pkg::word_width-1:0] mem_rdata
);
	import cache_pkg::*;

	logic [tag_width-1:0] tag, tag_out, fill_tag;
	logic [index_width-1:0] index, fill_index, array_index;
	logic [word_sel_width-1:0] word_sel, fill_word, array_word;
	logic [word_width-1:0] array_wdata;
	logic [addr_width-1:0] fill_addr; // block read address from the fsm
	logic valid, hit, miss, busy;
	logic fill_read, fill_write_data, fill_write_tag;
	logic array_write;

	// address split 5 / 7 / 4 with the byte bit ignored
	assign tag = addr[addr_width-1 -: tag_width];
	assign index = addr[addr_width-tag_width-1 -: index_width];
	assign word_sel = addr[word_sel_width:1];

	assign fill_tag = fill_addr[addr_width-1 -: tag_width];
	assign fill_index = fill_addr[addr_width-tag_width-1 -: index_width];

	assign hit = valid & (tag_out == tag); // one tag compare per direct mapped set
	assign miss = read & ~hit; // writes never allocate
	assign stall = busy | miss; // high from the miss cycle itself

	// arrays follow the fill while it runs and the pipeline otherwise
	assign array_index = busy ? fill_index : index;
	assign array_word = busy ? fill_word : word_sel;
	assign array_wdata = busy ? mem_rdata : wdata;
	// pipeline is stalled during a fill, so only fill words go in then
	assign array_write = busy ? fill_write_data : (write & hit);

	// write-through sends every write straight out
	assign mem_write = write;
	assign mem_wdata = wdata;
	assign mem_read = fill_read;
	assign mem_addr = write ? addr : fill_addr;

	cache_meta_array meta (
		.clk(clk),
		.rst(rst),
		.index(array_index),
		.tag_in(fill_tag),
		.write(fill_write_tag),
		.valid(valid),
		.tag_out(tag_out)
	);

	cache_data_array data (
		.clk(clk),
		.index(array_index),
		.word_sel(array_word),
		.wdata(array_wdata),
		.write(array_write),
		.rdata(rdata)
	);

	cache_fill_fsm fill (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.miss_addr(addr),
		.grant(mem_grant),
		.mem_valid(mem_valid),
		.busy(busy),
		.mem_read(fill_read),
		.mem_addr(fill_addr),
		.fill_word(fill_word),
		.write_data(fill_write_data),
		.write_tag(fill_write_tag)
	);

endmodule

`default_nettype wire

// File: cache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
	input  logic                               clk,
	input  logic [cache_pkg::index_width-1:0]    index,
	input  logic [cache_pkg::word_sel_width-1:0] word_sel,
	input  logic [cache_pkg::word_width-1:0]     wdata,
	input  logic                               write,
	output logic [cache_pkg::word_width-1:0]     rdata
);
	import cache_pkg::*;

	logic [word_width-1:0] words [num_sets * words_per_block]; // flat set-major store
	logic [index_width+word_sel_width-1:0] word_addr; // decoded set + word

	// set picks the block and word_sel the word inside it
	assign word_addr = {index, word_sel};

	assign rdata = words[word_addr]; // asynchronous read for same-cycle hits

	always_ff @(posedge clk) begin
		if (write) begin
			words[word_addr] <= wdata; // one word per edge from a fill or a write hit
		end
	end

endmodule

`default_nettype wire

// File: cache_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               miss,
	input  logic [cache_pkg::addr_width-1:0]     miss_addr,
	input  logic                               grant,
	input  logic                               mem_valid,
	output logic                               busy,
	output logic                               mem_read,
	output logic [cache_pkg::addr_width-1:0]     mem_addr,
	output logic [cache_pkg::word_sel_width-1:0] fill_word,
	output logic                               write_data,
	output logic                               write_tag
);
	import cache_pkg::*;

	fill_state_t state;
	logic [block_width-1:0] block_addr; // tag + set of the block being filled
	logic [word_sel_width-1:0] issue_cnt; // next word to request
	logic [word_sel_width-1:0] ret_cnt; // next word to come back
	logic last_issue; // eighth read granted this cycle
	logic last_return; // eighth word arriving this cycle

	assign busy = (state != fill_idle);
	assign mem_read = (state == fill_issue); // held until granted
	assign mem_addr = {block_addr, issue_cnt, 1'b0}; // word aligned

	assign write_data = busy & mem_valid; // arbiter only routes our returns
	assign fill_word = ret_cnt; // returns come back in issue order
	assign last_issue = grant & (issue_cnt == word_sel_width'(words_per_block - 1));
	assign last_return = write_data & (ret_cnt == word_sel_width'(words_per_block - 1));
	assign write_tag = last_return; // block valid only once all words are in

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fill_idle;
			issue_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			case (state)
				fill_idle: if (miss) state <= fill_issue; // start on cycle after miss
				fill_issue: if (last_issue) state <= fill_drain;
				fill_drain: if (last_return) state <= fill_idle;
				default: state <= fill_idle;
			endcase
			if (mem_read && grant) begin
				issue_cnt <= issue_cnt + 1'b1; // wraps to 0 after word 7
			end
			if (write_data) begin
				ret_cnt <= ret_cnt + 1'b1; // wraps to 0 after word 7
			end
		end
	end

	// block address captured once per miss
	always_ff @(posedge clk) begin
		if (state == fill_idle && miss) begin
			block_addr <= miss_addr[addr_width-1 -: block_width];
		end
	end

endmodule

`default_nettype wire

// File: cache_meta_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_meta_array (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [cache_pkg::index_width-1:0] index,
	input  logic [cache_pkg::tag_width-1:0]   tag_in,
	input  logic                            write,
	output logic                            valid,
	output logic [cache_pkg::tag_width-1:0]   tag_out
);
	import cache_pkg::*;

	logic [num_sets-1:0] valid_bits; // one valid flag per set
	logic [tag_width-1:0] tags [num_sets]; // one tag per set

	// asynchronous set lookup feeds the hit compare
	assign valid = valid_bits[index];
	assign tag_out = tags[index];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0; // every set empty after reset
		end else if (write) begin
			valid_bits[index] <= 1'b1; // filled block becomes valid
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= tag_in; // tag lands with the valid bit
		end
	end

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int addr_width = 16; // byte address into main memory
	localparam int word_width = 16; // one processor word

	localparam int tag_width = 5; // addr[15:11]
	localparam int index_width = 7; // addr[10:4] selects the set
	localparam int num_sets = 128; // 2**index_width

	localparam int words_per_block = 8; // 16-byte blocks
	localparam int word_sel_width = 3; // addr[3:1] picks the word inside the block

	// upper address bits that name a whole block (tag + set)
	localparam int block_width = tag_width + index_width;

	// fill controller states
	typedef enum logic [1:0] {
		fill_idle, // waiting for a read miss
		fill_issue, // sending the eight word reads
		fill_drain // waiting for the last returns
	} fill_state_t;

endpackage

`default_nettype wire

// File: main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory (
	input  logic                           clk,
	input  logic                           read,
	input  logic                           write,
	input  logic [cache_pkg::addr_width-1:0] addr,
	input  logic [cache_pkg::word_width-1:0] wdata,
	output logic                           rvalid,
	output logic [cache_pkg::word_width-1:0] rdata
);
	import cache_pkg::*;
	import mem_pkg::*;

	logic [word_width-1:0] mem [mem_words]; // word addressed store
	logic [addr_width-2:0] word_addr; // byte address without bit 0
	logic [mem_latency-1:0] valid_pipe; // one bit per read stage
	logic [word_width-1:0] data_pipe [mem_latency];

	assign word_addr = addr[addr_width-1:1];

	// power-up contents are the byte address xor the pattern
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = word_width'(i << 1) ^ mem_init_pattern;
		end
		valid_pipe = '0;
	end

	always @(posedge clk) begin
		if (write) begin
			mem[word_addr] <= wdata; // visible to the next read
		end
	end

	// data read at accept and carried down the stages
	always @(posedge clk) begin
		valid_pipe <= {valid_pipe[mem_latency-2:0], read};
		data_pipe[0] <= mem[word_addr];
		for (int k = 1; k < mem_latency; k++) begin
			data_pipe[k] <= data_pipe[k-1];
		end
	end

	assign rvalid = valid_pipe[mem_latency-1];
	assign rdata = data_pipe[mem_latency-1];

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           fetch_mem_read,
	input  logic                           fetch_mem_write,
	input  logic [cache_pkg::addr_width-1:0] fetch_mem_addr,
	input  logic [cache_pkg::word_width-1:0] fetch_mem_wdata,
	output logic                           fetch_mem_grant,
	output logic                           fetch_mem_valid,
	output logic [cache_pkg::word_width-1:0] fetch_mem_rdata,
	input  logic                           data_mem_read,
	input  logic                           data_mem_write,
	input  logic [cache_pkg::addr_width-1:0] data_mem_addr,
	input  logic [cache_pkg::word_width-1:0] data_mem_wdata,
	output logic                           data_mem_grant,
	output logic                           data_mem_valid,
	output logic [cache_pkg::word_width-1:0] data_mem_rdata,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic [cache_pkg::addr_width-1:0] mem_addr,
	output logic [cache_pkg::word_width-1:0] mem_wdata,
	input  logic                           mem_rvalid,
	input  logic [cache_pkg::word_width-1:0] mem_rdata
);
	import mem_pkg::*;

	requester_t read_owner; // requester of the read issued this cycle
	requester_t owner [mem_latency]; // lines up with the memory read pipe

	// fixed priority order is data write, fetch write, data read, fetch read
	always_comb begin
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_addr = data_mem_addr;
		mem_wdata = data_mem_wdata;
		fetch_mem_grant = 1'b0;
		data_mem_grant = 1'b0;
		read_owner = req_fetch;
		if (data_mem_write) begin
			mem_write = 1'b1; // writes never wait
		end else if (fetch_mem_write) begin
			mem_write = 1'b1;
			mem_addr = fetch_mem_addr;
			mem_wdata = fetch_mem_wdata;
		end else if (data_mem_read) begin
			mem_read = 1'b1;
			data_mem_grant = 1'b1;
			read_owner = req_data;
		end else if (fetch_mem_read) begin
			mem_read = 1'b1;
			fetch_mem_grant = 1'b1;
			mem_addr = fetch_mem_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < mem_latency; k++) begin
				owner[k] <= req_fetch;
			end
		end else begin
			owner[0] <= read_owner; // only meaningful when a read went out
			for (int k = 1; k < mem_latency; k++) begin
				owner[k] <= owner[k-1];
			end
		end
	end

	// word goes back only to the cache that asked for it
	assign fetch_mem_valid = mem_rvalid & (owner[mem_latency-1] == req_fetch);
	assign data_mem_valid = mem_rvalid & (owner[mem_latency-1] == req_data);
	assign fetch_mem_rdata = mem_rdata; // qualified by the valid above
	assign data_mem_rdata = mem_rdata;

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int mem_latency = 4; // cycles from read request to rvalid
	localparam int mem_words = 32768; // 64 KB of byte space in 16-bit words

	// word at byte address w powers up as w ^ mem_init_pattern
	localparam logic [15:0] mem_init_pattern = 16'h5a5a;

	// who owns a read in flight on the shared port
	typedef enum logic {
		req_fetch, // instruction cache
		req_data // data cache
	} requester_t;

endpackage

`default_nettype wire

// File: memory_system.f
cache_pkg.sv
mem_pkg.sv
cache_meta_array.sv
cache_data_array.sv
cache_fill_fsm.sv
cache.sv
mem_arbiter.sv
main_memory.sv
memory_system.sv
memory_tb_clock.sv
memory_system_tb.sv

// File: memory_system.sv
`timescale 1ns/1ps
`default_nettype none

module memory_system (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           fetch_read,
	input  logic [cache_pkg::addr_width-1:0] fetch_addr,
	output logic [cache_pkg::word_width-1:0] fetch_data,
	output logic                           fetch_stall,
	input  logic                           data_read,
	input  logic                           data_write,
	input  logic [cache_pkg::addr_width-1:0] data_addr,
	input  logic [cache_pkg::word_width-1:0] data_wdata,
	output logic [cache_pkg::word_width-1:0] data_rdata,
	output logic                           data_stall
);
	import cache_pkg::*;

	// instruction cache side of the arbiter
	logic f_read, f_write, f_grant, f_valid;
	logic [addr_width-1:0] f_addr;
	logic [word_width-1:0] f_wdata, f_rdata;
	// data cache side of the arbiter
	logic d_read, d_write, d_grant, d_valid;
	logic [addr_width-1:0] d_addr;
	logic [word_width-1:0] d_wdata, d_rdata;
	// single memory port
	logic m_read, m_write, m_rvalid;
	logic [addr_width-1:0] m_addr;
	logic [word_width-1:0] m_wdata, m_rdata;

	cache fetch_cache (
		.clk(clk), .rst(rst),
		.read(fetch_read), .write(1'b0), // instruction side never writes
		.addr(fetch_addr), .wdata('0),
		.rdata(fetch_data), .stall(fetch_stall),
		.mem_read(f_read), .mem_write(f_write),
		.mem_addr(f_addr), .mem_wdata(f_wdata),
		.mem_grant(f_grant), .mem_valid(f_valid), .mem_rdata(f_rdata)
	);

	cache data_cache (
		.clk(clk), .rst(rst),
		.read(data_read), .write(data_write),
		.addr(data_addr), .wdata(data_wdata),
		.rdata(data_rdata), .stall(data_stall),
		.mem_read(d_read), .mem_write(d_write),
		.mem_addr(d_addr), .mem_wdata(d_wdata),
		.mem_grant(d_grant), .mem_valid(d_valid), .mem_rdata(d_rdata)
	);

	mem_arbiter arbiter (
		.clk(clk), .rst(rst),
		.fetch_mem_read(f_read), .fetch_mem_write(f_write),
		.fetch_mem_addr(f_addr), .fetch_mem_wdata(f_wdata),
		.fetch_mem_grant(f_grant), .fetch_mem_valid(f_valid), .fetch_mem_rdata(f_rdata),
		.data_mem_read(d_read), .data_mem_write(d_write),
		.data_mem_addr(d_addr), .data_mem_wdata(d_wdata),
		.data_mem_grant(d_grant), .data_mem_valid(d_valid), .data_mem_rdata(d_rdata),
		.mem_read(m_read), .mem_write(m_write),
		.mem_addr(m_addr), .mem_wdata(m_wdata),
		.mem_rvalid(m_rvalid), .mem_rdata(m_rdata)
	);

	main_memory memory (
		.clk(clk),
		.read(m_read), .write(m_write),
		.addr(m_addr), .wdata(m_wdata),
		.rvalid(m_rvalid), .rdata(m_rdata)
	);

endmodule

`default_nettype wire

// File: memory_system_stimulus.txt
# port op addr wdata expect join lag stalls (addr, wdata, expect in hex)
# join 1 starts the row with the one above, lag in cycles from that start, stalls = stall cycles
fetch read  0100 0000 5b5a 0 0 13
fetch read  0106 0000 5b5c 0 0 0
fetch read  fffe 0000 a5a4 0 0 13
data  read  2040 0000 7a1a 0 0 13
data  read  204e 0000 7a14 0 0 0
data  write 2044 beef 0000 0 0 0
data  read  2044 0000 beef 0 0 0
data  read  2840 0000 721a 0 0 13
data  read  2044 0000 beef 0 0 13
data  read  2040 0000 7a1a 0 0 0
data  write 3000 1234 0000 0 0 0
data  read  3000 0000 1234 0 0 13
data  read  3002 0000 6a58 0 0 0
fetch read  3000 0000 1234 0 0 13
fetch read  4a20 0000 107a 0 0 21
data  read  6c30 0000 366a 1 0 13
fetch read  4a2e 0000 1074 0 0 0
fetch read  4a28 0000 1072 0 0 0
data  read  6c3e 0000 3664 0 0 0
data  read  6c36 0000 366c 0 0 0
fetch read  7e50 0000 240a 0 0 14
data  write 2046 cafe 0000 1 3 0
fetch read  7e5e 0000 2404 0 0 0
fetch read  7e56 0000 240c 0 0 0
data  read  2046 0000 cafe 0 0 0
data  read  2044 0000 beef 0 0 0

// File: memory_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_system_tb;
	import cache_pkg::*;

	localparam int max_lines = 64; // rows the access table can hold
	localparam int cycles_per_line = 40; // timeout budget per access

	logic clk;
	logic rst;
	logic fetch_read;
	logic [addr_width-1:0] fetch_addr;
	logic [word_width-1:0] fetch_data;
	logic fetch_stall;
	logic data_read;
	logic data_write;
	logic [addr_width-1:0] data_addr;
	logic [word_width-1:0] data_wdata;
	logic [word_width-1:0] data_rdata;
	logic data_stall;

	// access table with one row per stimulus line
	bit on_data [max_lines]; // 0 fetch port, 1 data port
	bit is_write [max_lines];
	logic [addr_width-1:0] acc_addr [max_lines];
	logic [word_width-1:0] acc_wdata [max_lines];
	logic [word_width-1:0] acc_expect [max_lines]; // read data from the file
	bit joins [max_lines]; // starts together with the row above
	int lag [max_lines]; // cycles after the group start
	int stall_expect [max_lines];
	bit done [max_lines];
	int stall_seen [max_lines]; // stall cycles counted so far

	int num_lines = 0;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0; // stays 0 until the table is loaded

	memory_tb_clock clock_gen (.clk(clk));

	memory_system dut (
		.clk(clk),
		.rst(rst),
		.fetch_read(fetch_read),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.fetch_stall(fetch_stall),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.data_stall(data_stall)
	);

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] time %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string text;
		logic [63:0] port_tok; // token lands right aligned
		logic [63:0] op_tok;
		int addr_v, wdata_v, expect_v, join_v, lag_v, stall_v;
		bit is_fetch, is_dport, is_rd, is_wr;
		fd = $fopen("memory_system_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open memory_system_stimulus.txt for reading");
			errors++;
		end else begin
			while (!$feof(fd) && num_lines < max_lines) begin
				text = "";
				n = $fgets(text, fd);
				if (n > 1 && text.getc(0) != "#") begin // skip blanks and column notes
					n = $sscanf(text, "%s %s %h %h %h %d %d %d", port_tok, op_tok,
						addr_v, wdata_v, expect_v, join_v, lag_v, stall_v);
					is_fetch = (port_tok == 64'("fetch"));
					is_dport = (port_tok == 64'("data"));
					is_rd = (op_tok == 64'("read"));
					is_wr = (op_tok == 64'("write"));
					if (n != 8 || !(is_fetch || is_dport) || !(is_rd || is_wr)
						|| (is_fetch && is_wr)) begin
						$display("stimulus line not understood: %0s", text);
						errors++;
					end else begin
						on_data[num_lines] = is_dport;
						is_write[num_lines] = is_wr;
						acc_addr[num_lines] = addr_v[15:0];
						acc_wdata[num_lines] = wdata_v[15:0];
						acc_expect[num_lines] = expect_v[15:0];
						joins[num_lines] = (join_v != 0);
						lag[num_lines] = lag_v;
						stall_expect[num_lines] = stall_v;
						done[num_lines] = 1'b0;
						stall_seen[num_lines] = 0;
						num_lines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// put one access on its port for the current cycle
	task automatic drive_access(input int i);
		if (on_data[i]) begin
			data_addr = acc_addr[i];
			data_wdata = acc_wdata[i];
			data_read = !is_write[i];
			data_write = is_write[i]; // strobe cleared at the next drive point
		end else begin
			fetch_addr = acc_addr[i];
			fetch_read = 1'b1; // held until stall drops
		end
	endtask

	// look at the port in mid cycle when everything has settled
	task automatic sample_access(input int i);
		if (is_write[i]) begin
			compare_value("data_stall", 16'(stall_expect[i]), {15'b0, data_stall});
			done[i] = 1'b1;
		end else if (on_data[i] ? data_stall : fetch_stall) begin
			stall_seen[i]++;
		end else if (on_data[i]) begin
			compare_value("data_rdata", acc_expect[i], data_rdata);
			compare_value("data_stall cycles", 16'(stall_expect[i]), 16'(stall_seen[i]));
			done[i] = 1'b1;
		end else begin
			compare_value("fetch_data", acc_expect[i], fetch_data);
			compare_value("fetch_stall cycles", 16'(stall_expect[i]), 16'(stall_seen[i]));
			done[i] = 1'b1;
		end
	endtask

	// rows first..last run side by side from their own lags
	task automatic run_group(input int first, input int last);
		int c;
		bit all_done;
		c = 0;
		all_done = 1'b0;
		while (!all_done) begin
			@(posedge clk);
			#1;
			fetch_read = 1'b0;
			data_read = 1'b0;
			data_write = 1'b0;
			for (int i = first; i <= last; i++) begin
				if (c >= lag[i] && !done[i]) drive_access(i);
			end
			@(negedge clk);
			all_done = 1'b1;
			for (int i = first; i <= last; i++) begin
				if (c >= lag[i] && !done[i]) sample_access(i);
				if (!done[i]) all_done = 1'b0;
			end
			c++;
		end
	endtask

	// watchdog armed once the table length is known
	always @(posedge clk) begin
		if (cycle_limit > 0) begin
			cycle_count++;
			if (cycle_count > cycle_limit) begin
				$display("timeout: accesses still running after %0d cycles", cycle_limit);
				$display("ERRORS FOUND");
				$finish;
			end
		end
	end

	initial begin
		int first;
		int last;
		rst = 1'b1;
		fetch_read = 1'b0;
		fetch_addr = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		compare_value("fetch_stall", 16'h0000, {15'b0, fetch_stall}); // quiet after reset
		compare_value("data_stall", 16'h0000, {15'b0, data_stall});
		load_stimulus();
		if (num_lines == 0 && errors == 0) begin
			$display("stimulus file holds no accesses");
			errors++;
		end
		cycle_limit = num_lines * cycles_per_line;
		first = 0;
		while (first < num_lines) begin
			last = first;
			while (last + 1 < num_lines && joins[last + 1]) last++;
			run_group(first, last);
			first = last + 1;
		end
		@(posedge clk);
		#1;
		fetch_read = 1'b0; // leave both ports idle
		data_read = 1'b0;
		data_write = 1'b0;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: memory_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module memory_tb_clock (
	output logic clk
);
	localparam int half_period = 2; // 4 ns period

	initial clk = 1'b0;

	always #half_period clk = ~clk; // free running clock

endmodule

`default_nettype wire
